// File: files.f
design/bldc_pkg.sv
design/hall_monitor.sv
design/commutation_decoder.sv
design/drive_fsm.sv
design/phase_pwm.sv
design/bldc_driver.sv
tests/tb_bldc_driver.sv

// File: tests/bldc_stimulus.txt
# test en hall dir duty wait exp_fault exp_connected exp_high_mask exp_low_mask
# hall and both masks are binary, mask bit 0 is phase A
1 0 101 0 0   300 0 1 000 000
1 1 101 0 5   300 0 1 000 000
1 1 011 0 3   300 0 1 000 000
2 1 101 0 200 600 0 1 001 011
2 1 100 0 200 600 0 1 001 101
2 1 110 0 200 600 0 1 010 110
2 1 010 0 200 600 0 1 010 011
2 1 011 0 200 600 0 1 100 101
2 1 001 0 200 600 0 1 100 110
3 1 101 1 150 600 0 1 010 011
3 1 100 1 150 600 0 1 100 101
3 1 110 1 150 600 0 1 100 110
3 1 010 1 150 600 0 1 001 011
3 1 011 1 150 600 0 1 001 101
3 1 001 1 150 600 0 1 010 110
5 1 000 0 200 300 1 1 000 000
5 1 111 0 200 300 0 0 000 000
6 1 101 0 200 800 0 1 001 011
6 1 111 0 200 300 0 0 000 000
6 1 110 0 200 800 0 1 010 110
6 1 000 0 200 300 1 1 000 000
6 0 000 0 200 300 0 1 000 000

// File: tests/tb_bldc_driver.sv
/* BLDC driver testbench */

`timescale 1ns/1ps

module tb_bldc_driver;
    import bldc_pkg::*;

    // One line of the stimulus file
    typedef struct packed {
        int          test;
        logic        en;
        hall_t       hall;
        logic        dir;
        duty_t       duty;
        int          wait_cycles;
        logic        exp_fault;
        logic        exp_connected;
        phase_mask_t exp_h;
        phase_mask_t exp_l;
    } step_t;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        en;
    hall_t       hall;
    logic        direction;
    duty_t       duty_request;
    phase_mask_t phase_h;
    phase_mask_t phase_l;
    logic        fault;
    logic        connected;

    step_t       steps [$];
    int          test_checks [8];
    int          test_errors [8];
    int          cycle_count = 0;
    int          cycle_limit = 32'h7fff_ffff;
    int          step_in_test;
    int          total_errors;
    int          total_checks;
    logic        load_ok;

    bldc_driver DUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .en           (en),
        .hall         (hall),
        .duty_request (duty_request),
        .direction    (direction),
        .phase_h      (phase_h),
        .phase_l      (phase_l),
        .fault        (fault),
        .connected    (connected)
    );

    always #4 clk = ~clk;

    // ======================================================================
    // Run limit and per-cycle shoot-through check (test 4)
    // ======================================================================
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: the run did not end within %0d cycles", cycle_limit);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    // Outputs are registered on the rising edge, so the falling edge sees them settled
    always @(negedge clk) begin
        if (rst_n) begin
            test_checks[4]++;
            assert ((phase_h & phase_l) == '0) else begin
                $display("[ERROR] shoot-through: phase_h = 0x%h, phase_l = 0x%h at cycle %0d",
                         phase_h, phase_l, cycle_count);
                test_errors[4]++;
            end
        end
    end

    // ======================================================================
    // Helpers
    // ======================================================================
    task automatic load_steps();
        int    fd;
        int    code;
        int    n;
        int    t, e, d, du, w, f, c;
        logic  [2:0] h, mh, ml;
        string line;
        load_ok = 1'b0;
        fd = $fopen("tests/bldc_stimulus.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                code = $fgets(line, fd);
                // Lines that open with a hash carry the column legend
                if ((code > 0) && (line.len() > 1) && (line.getc(0) != "#")) begin
                    n = $sscanf(line, "%d %d %b %d %d %d %d %d %b %b",
                                t, e, h, d, du, w, f, c, mh, ml);
                    if (n == 10) begin
                        steps.push_back('{t, e[0], h, d[0], du[7:0], w, f[0], c[0], mh, ml});
                    end
                end
            end
            $fclose(fd);
            load_ok = (steps.size() > 0);
        end
    endtask

    // Rows of one test are independent once the motor runs, so their order may vary
    task automatic shuffle_test(input int test_num);
        int    idx [$];
        int    j;
        step_t tmp;
        foreach (steps[k]) begin
            if (steps[k].test == test_num) begin
                idx.push_back(k);
            end
        end
        for (int k = idx.size() - 1; k > 0; k--) begin
            j = $urandom % (k + 1);
            tmp = steps[idx[k]];
            steps[idx[k]] = steps[idx[j]];
            steps[idx[j]] = tmp;
        end
    endtask

    task automatic check_value(input int test_num, input int step_num, input string name,
                               input logic [7:0] got, input logic [7:0] exp);
        test_checks[test_num]++;
        assert (got === exp) else begin
            $display("[ERROR] test %0d step %0d: %s = 0x%h, expected 0x%h",
                     test_num, step_num, name, got, exp);
            test_errors[test_num]++;
        end
    endtask

    // Apply one row, then OR the gates together over the final PWM period
    task automatic run_step(input step_t s, input int step_num);
        phase_mask_t seen_h;
        phase_mask_t seen_l;
        int          window_start;
        seen_h = '0;
        seen_l = '0;
        window_start = s.wait_cycles - PWM_PERIOD;
        @(posedge clk);
        en           <= s.en;
        hall         <= s.hall;
        direction    <= s.dir;
        duty_request <= s.duty;
        for (int i = 0; i < s.wait_cycles; i++) begin
            @(negedge clk);
            if (i >= window_start) begin
                seen_h = seen_h | phase_h;
                seen_l = seen_l | phase_l;
            end
        end
        check_value(s.test, step_num, "fault", 8'(fault), 8'(s.exp_fault));
        check_value(s.test, step_num, "connected", 8'(connected), 8'(s.exp_connected));
        check_value(s.test, step_num, "phase_h seen", 8'(seen_h), 8'(s.exp_h));
        check_value(s.test, step_num, "phase_l seen", 8'(seen_l), 8'(s.exp_l));
    endtask

    task automatic report_test(input int test_num);
        $display("test %0d: %s, %0d checks, %0d errors", test_num,
                 (test_errors[test_num] == 0) ? "passed" : "failed",
                 test_checks[test_num], test_errors[test_num]);
    endtask

    // ======================================================================
    // Main sequence
    // ======================================================================
    initial begin
        rst_n        = 1'b0;
        en           = 1'b0;
        hall         = 3'b101;
        direction    = 1'b0;
        duty_request = '0;
        void'($urandom(76));
        load_steps();
        if (!load_ok) begin
            $display("Could not read any step from tests/bldc_stimulus.txt");
            $display("FAIL: see errors above");
            $finish;
        end else begin
            shuffle_test(3);
            cycle_limit = 16 + 500;
            foreach (steps[k]) begin
                cycle_limit += steps[k].wait_cycles;
            end
            repeat (16) @(posedge clk);
            rst_n <= 1'b1;
            step_in_test = 0;
            for (int s = 0; s < steps.size(); s++) begin
                run_step(steps[s], step_in_test);
                step_in_test++;
                if ((s == steps.size() - 1) || (steps[s + 1].test != steps[s].test)) begin
                    report_test(steps[s].test);
                    step_in_test = 0;
                end
            end
            report_test(4);
            total_errors = 0;
            total_checks = 0;
            for (int t = 0; t < 8; t++) begin
                total_errors += test_errors[t];
                total_checks += test_checks[t];
            end
            $display("done: %0d checks, %0d errors", total_checks, total_errors);
            if (total_errors == 0) begin
                $display("PASS: all tests");
            end else begin
                $display("FAIL: see errors above");
            end
            $finish;
        end
    end

endmodule

// File: design/bldc_driver.sv
/* Sensored BLDC driver top level */

`timescale 1ns/1ps

module bldc_driver (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       en,
    input  bldc_pkg::hall_t            hall,
    input  bldc_pkg::duty_t            duty_request,
    input  logic                       direction,
    output wire bldc_pkg::phase_mask_t phase_h,
    output wire bldc_pkg::phase_mask_t phase_l,
    output logic                       fault,
    output logic                       connected
);
    import bldc_pkg::*;

    hall_status_t status;
    motor_cmd_t   cmd;
    logic         polling;
    phase_ctrl_t  phase_ctrl [NUM_PHASES];

    hall_monitor u_hall_monitor (
        .clk     (clk),
        .rst_n   (rst_n),
        .en      (en),
        .hall    (hall),
        .polling (polling),
        .status  (status)
    );

    drive_fsm u_drive_fsm (
        .clk          (clk),
        .rst_n        (rst_n),
        .en           (en),
        .duty_request (duty_request),
        .status       (status),
        .polling      (polling),
        .cmd          (cmd),
        .fault        (fault),
        .connected    (connected)
    );

    // Commutation follows the synchronised code, not the raw pins
    commutation_decoder u_commutation_decoder (
        .hall       (status.hall),
        .direction  (direction),
        .cmd        (cmd),
        .phase_ctrl (phase_ctrl)
    );

    for (genvar i = 0; i < NUM_PHASES; i++) begin : g_phase
        phase_pwm u_phase_pwm (
            .clk    (clk),
            .rst_n  (rst_n),
            .ctrl   (phase_ctrl[i]),
            .gate_h (phase_h[i]),
            .gate_l (phase_l[i])
        );
    end

    // A reported fault means every gate is already off by the next cycle
    a_fault_gates_off: assert property (@(posedge clk) disable iff (!rst_n)
        fault |=> ((phase_h == '0) && (phase_l == '0)));

endmodule

// File: design/phase_pwm.sv
/* Phase PWM with dead time */

`timescale 1ns/1ps

module phase_pwm (
    input  logic                  clk,
    input  logic                  rst_n,
    input  bldc_pkg::phase_ctrl_t ctrl,
    output logic                  gate_h,
    output logic                  gate_l
);
    import bldc_pkg::*;

    logic [PWM_CNT_W-1:0]  pwm_cnt;
    logic [DEAD_CNT_W-1:0] dead_cnt;
    logic                  level_q;
    logic                  want_h;
    logic                  settled;

    // The high side is wanted for the first duty counts of every period
    // and only on the source phase
    assign want_h = ctrl.source && (pwm_cnt < ctrl.duty);

    // Gates may follow the wanted level only once the dead time has run out
    assign settled = (want_h == level_q) && (dead_cnt == '0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pwm_cnt  <= '0;
            dead_cnt <= '0;
            level_q  <= 1'b0;
            gate_h   <= 1'b0;
            gate_l   <= 1'b0;
        end else begin
            // Free-running counter, one wrap per PWM_PERIOD
            pwm_cnt <= pwm_cnt + 1'b1;

            // Every edge of the wanted level restarts the blanking interval
            if (want_h != level_q) begin
                level_q  <= want_h;
                dead_cnt <= DEAD_CNT_W'(DEAD_TIME - 1);
            end else if (dead_cnt != '0) begin
                dead_cnt <= dead_cnt - 1'b1;
            end

            gate_h <= !ctrl.high_z && settled && want_h;
            gate_l <= !ctrl.high_z && settled && !want_h;
        end
    end

    a_no_shoot_through: assert property (@(posedge clk) disable iff (!rst_n)
        !(gate_h && gate_l));

endmodule

// File: design/drive_fsm.sv
/* Motor drive state machine */

`timescale 1ns/1ps

module drive_fsm (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   en,
    input  bldc_pkg::duty_t        duty_request,
    input  bldc_pkg::hall_status_t status,
    output logic                   polling,
    output bldc_pkg::motor_cmd_t   cmd,
    output logic                   fault,
    output logic                   connected
);
    import bldc_pkg::*;

    drive_state_e          state;
    drive_state_e          state_next;
    logic [RAMP_CNT_W-1:0] ramp_cnt;
    logic [STEP_CNT_W-1:0] step_cnt;
    logic                  below_min;
    logic                  ramp_tick;
    logic                  ramp_last;

    assign below_min = (duty_request <= DUTY_MIN);
    assign ramp_tick = (ramp_cnt == RAMP_CNT_W'(STARTUP_STEP_CYCLES - 1));
    // The last ramp step hands the motor over to the requested duty
    assign ramp_last = ramp_tick && (step_cnt == STEP_CNT_W'(STARTUP_STEPS - 1));

    // ======================================================================
    // Next-state logic
    // ======================================================================
    always_comb begin
        state_next = state;
        case (state)
            STOP: begin
                if (!below_min) begin
                    state_next = STARTUP;
                end
            end
            STARTUP: begin
                if (below_min) begin
                    state_next = STOP;
                end else if (ramp_last) begin
                    state_next = RUN;
                end
            end
            RUN: begin
                if (below_min) begin
                    state_next = STOP;
                end
            end
            POLL_HALL: begin
                // A stale hw_fault from ERR is ignored unless the code is really low
                if (status.hw_fault && (status.hall == HALL_STUCK_LOW)) begin
                    state_next = ERR;
                end else if (!status.disconnected && !status.hw_fault
                             && hall_valid(status.hall)) begin
                    state_next = STOP;
                end
            end
            ERR: begin
                // Unplugging the sensor is the other way out of a fault
                if (status.hall == HALL_STUCK_HIGH) begin
                    state_next = POLL_HALL;
                end
            end
            default: begin
                state_next = STOP;
            end
        endcase

        // Sensor faults preempt the normal sequence
        if ((state != ERR) && (state != POLL_HALL)) begin
            if (status.hw_fault) begin
                state_next = ERR;
            end else if (status.disconnected) begin
                state_next = POLL_HALL;
            end
        end

        if (!en) begin
            state_next = STOP;
        end
    end

    // ======================================================================
    // State, ramp and command registers
    // ======================================================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= STOP;
            ramp_cnt  <= '0;
            step_cnt  <= '0;
            cmd       <= '0;
            fault     <= 1'b0;
            connected <= 1'b1;
        end else begin
            state      <= state_next;
            fault      <= (state_next == ERR);
            connected  <= ~status.disconnected;
            cmd.enable <= (state_next == STARTUP) || (state_next == RUN);

            case (state_next)
                STARTUP: begin
                    if (state != STARTUP) begin
                        // The ramp always starts from the lowest running duty
                        ramp_cnt <= '0;
                        step_cnt <= '0;
                        cmd.duty <= DUTY_MIN;
                    end else if (ramp_tick) begin
                        ramp_cnt <= '0;
                        step_cnt <= step_cnt + 1'b1;
                        // Never ramp past what was asked for
                        if (cmd.duty < duty_request) begin
                            cmd.duty <= cmd.duty + 1'b1;
                        end
                    end else begin
                        ramp_cnt <= ramp_cnt + 1'b1;
                    end
                end
                RUN: begin
                    cmd.duty <= duty_request;
                end
                default: begin
                    cmd.duty <= '0;
                end
            endcase
        end
    end

    assign polling = (state == POLL_HALL);

    a_enable_only_driving: assert property (@(posedge clk) disable iff (!rst_n)
        ((state != STARTUP) && (state != RUN)) |-> !cmd.enable);

endmodule

// File: design/commutation_decoder.sv
/* Six-step commutation decoder */

`timescale 1ns/1ps

module commutation_decoder (
    input  bldc_pkg::hall_t      hall,
    input  logic                 direction,
    input  bldc_pkg::motor_cmd_t cmd,
    output bldc_pkg::phase_ctrl_t phase_ctrl [bldc_pkg::NUM_PHASES]
);
    import bldc_pkg::*;

    comm_entry_t entry;
    phase_mask_t src;
    phase_mask_t snk;

    assign entry = COMM_TABLE[hall];

    // Direction high selects reverse rotation, which swaps the driven pair
    assign src = direction ? entry.sink : entry.source;
    assign snk = direction ? entry.source : entry.sink;

    always_comb begin
        for (int i = 0; i < NUM_PHASES; i++) begin
            // The source phase switches at the commanded duty
            phase_ctrl[i].source = src[i];
            // The sink phase holds its low side on through a zero duty
            phase_ctrl[i].duty   = src[i] ? cmd.duty : '0;
            // Undriven phases float, and so does every phase while disabled
            phase_ctrl[i].high_z = !cmd.enable || !(src[i] || snk[i]);
        end
    end

endmodule

// File: design/hall_monitor.sv
/* Hall sensor monitor */

`timescale 1ns/1ps

module hall_monitor (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   en,
    input  bldc_pkg::hall_t        hall,
    input  logic                   polling,
    output bldc_pkg::hall_status_t status
);
    import bldc_pkg::*;

    hall_t                   hall_q;
    logic [SAMPLE_CNT_W-1:0] sample_cnt;
    logic [STEADY_CNT_W-1:0] low_cnt;
    logic [STEADY_CNT_W-1:0] high_cnt;
    logic [STEADY_CNT_W-1:0] valid_cnt;
    logic                    hw_fault;
    logic                    disconnected;
    logic                    sample_tick;
    logic                    low_done;
    logic                    high_done;
    logic                    valid_done;

    // The sensor is sampled once per divider wrap to ride over short glitches
    assign sample_tick = (sample_cnt == SAMPLE_CNT_W'(HALL_SAMPLE_CYCLES - 1));

    // A run completes on the sample that brings its count to HALL_STEADY_COUNT
    assign low_done   = sample_tick && (hall_q == HALL_STUCK_LOW)
                        && (low_cnt == STEADY_CNT_W'(HALL_STEADY_COUNT - 1));
    assign high_done  = sample_tick && (hall_q == HALL_STUCK_HIGH)
                        && (high_cnt == STEADY_CNT_W'(HALL_STEADY_COUNT - 1));
    assign valid_done = sample_tick && polling && hall_valid(hall_q)
                        && (valid_cnt == STEADY_CNT_W'(HALL_STEADY_COUNT - 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hall_q       <= '0;
            sample_cnt   <= '0;
            low_cnt      <= '0;
            high_cnt     <= '0;
            valid_cnt    <= '0;
            hw_fault     <= 1'b0;
            disconnected <= 1'b0;
        end else begin
            hall_q     <= hall;
            sample_cnt <= sample_tick ? '0 : sample_cnt + 1'b1;

            if (!en) begin
                // Dropping the enable is the user's way of clearing faults
                low_cnt      <= '0;
                high_cnt     <= '0;
                valid_cnt    <= '0;
                hw_fault     <= 1'b0;
                disconnected <= 1'b0;
            end else if (sample_tick) begin
                // Each run counter saturates and restarts on any other code
                if (hall_q != HALL_STUCK_LOW) begin
                    low_cnt <= '0;
                end else if (low_cnt != STEADY_CNT_W'(HALL_STEADY_COUNT)) begin
                    low_cnt <= low_cnt + 1'b1;
                end
                if (hall_q != HALL_STUCK_HIGH) begin
                    high_cnt <= '0;
                end else if (high_cnt != STEADY_CNT_W'(HALL_STEADY_COUNT)) begin
                    high_cnt <= high_cnt + 1'b1;
                end
                if (!polling || !hall_valid(hall_q)) begin
                    valid_cnt <= '0;
                end else if (valid_cnt != STEADY_CNT_W'(HALL_STEADY_COUNT)) begin
                    valid_cnt <= valid_cnt + 1'b1;
                end

                // The two fault latches replace each other, never coexist
                if (low_done) begin
                    hw_fault     <= 1'b1;
                    disconnected <= 1'b0;
                end else if (high_done) begin
                    hw_fault     <= 1'b0;
                    disconnected <= 1'b1;
                end else if (valid_done) begin
                    // A steady valid code means a healthy sensor is back
                    hw_fault     <= 1'b0;
                    disconnected <= 1'b0;
                end
            end
        end
    end

    assign status = '{hall: hall_q, hw_fault: hw_fault, disconnected: disconnected};

    a_fault_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(hw_fault && disconnected));

    a_count_bound: assert property (@(posedge clk) disable iff (!rst_n)
        (low_cnt <= HALL_STEADY_COUNT) && (high_cnt <= HALL_STEADY_COUNT)
        && (valid_cnt <= HALL_STEADY_COUNT));

endmodule

// File: design/bldc_pkg.sv
/* BLDC driver shared definitions */

package bldc_pkg;

    // ======================================================================
    // Widths and timing
    // ======================================================================
    localparam int DUTY_W              = 8;
    localparam int HALL_W              = 3;
    localparam int NUM_PHASES          = 3;

    localparam int PWM_PERIOD          = 256;
    localparam int DEAD_TIME           = 4;
    localparam int STARTUP_STEP_CYCLES = 16;
    localparam int STARTUP_STEPS       = 16;
    localparam int HALL_SAMPLE_CYCLES  = 4;
    localparam int HALL_STEADY_COUNT   = 8;

    // Counter widths derived from the timing above
    localparam int PWM_CNT_W    = $clog2(PWM_PERIOD);
    localparam int DEAD_CNT_W   = $clog2(DEAD_TIME);
    localparam int RAMP_CNT_W   = $clog2(STARTUP_STEP_CYCLES);
    localparam int STEP_CNT_W   = $clog2(STARTUP_STEPS);
    localparam int SAMPLE_CNT_W = $clog2(HALL_SAMPLE_CYCLES);
    localparam int STEADY_CNT_W = $clog2(HALL_STEADY_COUNT + 1);

    // ======================================================================
    // Types
    // ======================================================================
    typedef logic [DUTY_W-1:0]     duty_t;
    typedef logic [HALL_W-1:0]     hall_t;
    typedef logic [NUM_PHASES-1:0] phase_mask_t;

    // Requests at or below this level stop the motor (about 2% of full scale)
    localparam duty_t DUTY_MIN        = 8'd5;
    localparam hall_t HALL_STUCK_LOW  = 3'b000;
    localparam hall_t HALL_STUCK_HIGH = 3'b111;

    typedef enum logic [2:0] {
        STOP,
        STARTUP,
        RUN,
        POLL_HALL,
        ERR
    } drive_state_e;

    typedef struct packed {
        hall_t hall;
        logic  hw_fault;
        logic  disconnected;
    } hall_status_t;

    // One phase's command; source selects the high-side PWM leg
    typedef struct packed {
        duty_t duty;
        logic  high_z;
        logic  source;
    } phase_ctrl_t;

    typedef struct packed {
        logic  enable;
        duty_t duty;
    } motor_cmd_t;

    // ======================================================================
    // Six-step commutation, forward rotation, indexed by hall code
    // ======================================================================
    typedef struct packed {
        phase_mask_t source;
        phase_mask_t sink;
    } comm_entry_t;

    // Bit 0 is phase A, bit 2 is phase C
    localparam comm_entry_t COMM_TABLE [8] = '{
        '{3'b000, 3'b000},  // 000 stuck low, all float
        '{3'b100, 3'b010},  // 001 C to B
        '{3'b010, 3'b001},  // 010 B to A
        '{3'b100, 3'b001},  // 011 C to A
        '{3'b001, 3'b100},  // 100 A to C
        '{3'b001, 3'b010},  // 101 A to B
        '{3'b010, 3'b100},  // 110 B to C
        '{3'b000, 3'b000}   // 111 disconnected, all float
    };

    // True for the six codes that a healthy sensor can produce
    function automatic logic hall_valid(hall_t code);
        return (code != HALL_STUCK_LOW) && (code != HALL_STUCK_HIGH);
    endfunction

endpackage
